// ==== verilog/tcdm_pkg.sv ====
package tcdm_pkg;

  // ########################################
  // Cluster geometry
  // ########################################

  // Number of initiators sharing the banks
  localparam int unsigned NB_INIT = 4;

  // Number of word-interleaved banks
  localparam int unsigned NB_BANK = 2;

  localparam int unsigned DW = 32;      // Data word width in bits
  localparam int unsigned BW = DW / 8;  // One byte enable per data byte

  // Word address width
  // Bit 0 picks the bank and the upper bits give the row inside it
  localparam int unsigned AW = 10;

  // Rows held by one bank, which is 2**(AW-1)
  localparam int unsigned BANK_WORDS = 512;

  // Width of the initiator tag carried in id and r_id
  localparam int unsigned IW = $clog2(NB_INIT);

  // ########################################
  // Opcodes
  // ########################################

  // Same polarity as the classic TCDM wen bit, where high means read
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } tcdm_op_e;

  // ########################################
  // Request and response bundles
  // ########################################

  // Request from an initiator towards a bank
  // The id field is filled in by the bank arbiter
  typedef struct packed {
    logic          req;   // Request strobe
    logic [AW-1:0] add;   // Word address
    tcdm_op_e      op;    // Read or write
    logic [BW-1:0] be;    // Byte enables for writes
    logic [DW-1:0] data;  // Write data
    logic [IW-1:0] id;    // Initiator tag
  } tcdm_req_t;

  // Read response travelling back to the initiator
  // Writes never produce one
  typedef struct packed {
    logic          r_valid;  // High for one cycle per granted read
    logic [DW-1:0] r_data;   // Read data
    logic [IW-1:0] r_id;     // Tag of the initiator that asked
  } tcdm_rsp_t;

endpackage

// ==== verilog/tcdm_r_id_filter.sv ====
`timescale 1ns/1ns

// Strips the id from a request on its way into a bank and puts it back on the response
// Only correct where a granted read always answers in the very next cycle
module tcdm_r_id_filter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                enable_i,
  input  tcdm_pkg::tcdm_req_t target_req,  // From the bank arbiter
  output logic                target_gnt,
  output tcdm_pkg::tcdm_rsp_t target_rsp,
  output tcdm_pkg::tcdm_req_t init_req,    // Towards the memory bank
  input  logic                init_gnt,
  input  tcdm_pkg::tcdm_rsp_t init_rsp
);

  logic [tcdm_pkg::IW-1:0] id_q;  // Tag of the last request seen

  // Request goes through untouched except for the id, which the bank has no use for
  always_comb begin
    init_req    = target_req;
    init_req.id = '0;
  end

  assign target_gnt = init_gnt;  // Bank grant goes straight back up

  // Valid and data pass through and the stored tag replaces the bank's r_id
  assign target_rsp.r_valid = init_rsp.r_valid;
  assign target_rsp.r_data  = init_rsp.r_data;
  assign target_rsp.r_id    = id_q;

  // The tag is captured on every request, granted or not
  // Since the bank grants whatever it sees this matches the read answered next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (clear_i) begin
      id_q <= '0;  // Clear wins over a capture in the same cycle
    end else if (enable_i && target_req.req) begin
      id_q <= target_req.id;
    end
  end

endmodule

// ==== verilog/tcdm_bank_arbiter.sv ====
`timescale 1ns/1ns

// Round-robin arbiter in front of one bank
// Picks one initiator per cycle and tags its request with the initiator index
module tcdm_bank_arbiter #(
  parameter int unsigned BANK_IDX = 0  // Bank served by this arbiter
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  tcdm_pkg::tcdm_req_t         init_req [tcdm_pkg::NB_INIT],
  output logic [tcdm_pkg::NB_INIT-1:0] init_gnt,
  output tcdm_pkg::tcdm_req_t         bank_req,
  input  logic                        bank_gnt
);

  // ########################################
  // Request masking
  // ########################################

  // One bit per initiator that wants this bank right now
  logic [tcdm_pkg::NB_INIT-1:0] hit;

  always_comb begin
    for (int unsigned i = 0; i < tcdm_pkg::NB_INIT; i++) begin
      // The lowest address bit decides which bank a word lives in
      hit[i] = init_req[i].req && (init_req[i].add[0] == BANK_IDX[0]);
    end
  end

  // ########################################
  // Winner selection
  // ########################################

  logic [tcdm_pkg::IW-1:0] rr_q;   // Initiator with the highest priority this cycle
  logic [tcdm_pkg::IW-1:0] cand;   // Initiator under inspection in the search loop
  logic [tcdm_pkg::IW-1:0] win;    // Selected initiator
  logic                    found;  // Some initiator wants this bank

  // Search starts at the pointer and wraps around
  // The id width covers exactly NB_INIT entries so the addition wraps on its own
  always_comb begin
    found = 1'b0;
    win   = '0;
    cand  = '0;
    for (int unsigned off = 0; off < tcdm_pkg::NB_INIT; off++) begin
      cand = rr_q + off[tcdm_pkg::IW-1:0];
      if (!found && hit[cand]) begin
        found = 1'b1;
        win   = cand;
      end
    end
  end

  // ########################################
  // Forwarding and grant return
  // ########################################

  // Winner's request goes to the bank with the tag stamped in
  always_comb begin
    if (found) begin
      bank_req     = init_req[win];
      bank_req.id  = win;
      bank_req.req = 1'b1;
    end else begin
      bank_req = '0;  // No request means req stays low
    end
  end

  // Only the winner sees the bank grant
  always_comb begin
    init_gnt = '0;
    if (found) begin
      init_gnt[win] = bank_gnt;
    end
  end

  // ########################################
  // Round-robin pointer
  // ########################################

  // After a grant the winner drops to lowest priority
  // Under steady contention each requester waits at most NB_INIT grants
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (found && bank_gnt) begin
      rr_q <= win + 1'b1;  // Wraps from the last initiator back to 0
    end
  end

endmodule

// ==== verilog/tcdm_bank_mem.sv ====
`timescale 1ns/1ns

// Single-ported word memory with byte enables
// Every request is granted at once and a read answers exactly one cycle later
module tcdm_bank_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::tcdm_req_t mem_req,
  output logic                mem_gnt,
  output tcdm_pkg::tcdm_rsp_t mem_rsp
);

  logic [tcdm_pkg::DW-1:0] mem_q [tcdm_pkg::BANK_WORDS];  // Storage array
  logic [tcdm_pkg::AW-2:0] row;                           // Row inside this bank
  logic                    wr_en;
  logic                    rd_en;
  logic [tcdm_pkg::DW-1:0] rdata_q;                       // Registered read word
  logic                    rvalid_q;

  // Bank bit is dropped since the arbiter already routed on it
  assign row = mem_req.add[tcdm_pkg::AW-1:1];

  // The bank never stalls so a request is a grant
  assign mem_gnt = mem_req.req;

  assign wr_en = mem_req.req && (mem_req.op == tcdm_pkg::OP_WRITE);
  assign rd_en = mem_req.req && (mem_req.op == tcdm_pkg::OP_READ);

  // Write lands at the grant edge and touches only the enabled bytes
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < tcdm_pkg::BW; b++) begin
        if (mem_req.be[b]) begin
          mem_q[row][b*8 +: 8] <= mem_req.data[b*8 +: 8];
        end
      end
    end
  end

  // Read word is captured at the grant edge
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= mem_q[row];
    end
  end

  // Valid strobe lasts exactly one cycle per granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  assign mem_rsp.r_valid = rvalid_q;
  assign mem_rsp.r_data  = rdata_q;
  assign mem_rsp.r_id    = '0;  // The id filter above fills in the real tag

endmodule

// ==== verilog/tcdm_resp_router.sv ====
`timescale 1ns/1ns

// Sends each bank read response to the initiator named in its r_id
// Purely combinational
module tcdm_resp_router (
  input  tcdm_pkg::tcdm_rsp_t bank_rsp [tcdm_pkg::NB_BANK],
  output tcdm_pkg::tcdm_rsp_t init_rsp [tcdm_pkg::NB_INIT]
);

  // ########################################
  // Per-initiator selection
  // ########################################

  // Match flags for each initiator and bank pair
  logic [tcdm_pkg::NB_BANK-1:0] match [tcdm_pkg::NB_INIT];

  always_comb begin
    for (int unsigned i = 0; i < tcdm_pkg::NB_INIT; i++) begin
      for (int unsigned b = 0; b < tcdm_pkg::NB_BANK; b++) begin
        // A bank answers initiator i only with a valid response tagged i
        match[i][b] = bank_rsp[b].r_valid
                      && (bank_rsp[b].r_id == i[tcdm_pkg::IW-1:0]);
      end
    end
  end

  // An initiator has at most one request in flight per cycle
  // So at most one bank can match and the loop order does not matter
  always_comb begin
    for (int unsigned i = 0; i < tcdm_pkg::NB_INIT; i++) begin
      init_rsp[i] = '0;  // Nothing for this initiator by default
      for (int unsigned b = 0; b < tcdm_pkg::NB_BANK; b++) begin
        if (match[i][b]) begin
          init_rsp[i] = bank_rsp[b];
        end
      end
    end
  end

endmodule

// ==== verilog/tcdm_cluster_top.sv ====
`timescale 1ns/1ns

// Four initiators sharing two interleaved banks
// Each bank has its own arbiter and id filter and one router collects the responses
module tcdm_cluster_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         enable_i,
  input  tcdm_pkg::tcdm_req_t          init_req [tcdm_pkg::NB_INIT],
  output logic [tcdm_pkg::NB_INIT-1:0] init_gnt,
  output tcdm_pkg::tcdm_rsp_t          init_rsp [tcdm_pkg::NB_INIT]
);

  // ########################################
  // Per-bank wiring
  // ########################################

  tcdm_pkg::tcdm_req_t          arb_req [tcdm_pkg::NB_BANK];  // Arbiter to filter
  logic [tcdm_pkg::NB_BANK-1:0] flt_gnt;                      // Filter grant to arbiter
  tcdm_pkg::tcdm_rsp_t          flt_rsp [tcdm_pkg::NB_BANK];  // Tagged responses
  tcdm_pkg::tcdm_req_t          mem_req [tcdm_pkg::NB_BANK];  // Filter to bank
  logic [tcdm_pkg::NB_BANK-1:0] mem_gnt;
  tcdm_pkg::tcdm_rsp_t          mem_rsp [tcdm_pkg::NB_BANK];  // Untagged responses
  logic [tcdm_pkg::NB_INIT-1:0] arb_gnt [tcdm_pkg::NB_BANK];  // Grant vector of each arbiter

  for (genvar b = 0; b < tcdm_pkg::NB_BANK; b++) begin : gen_bank
    tcdm_bank_arbiter #(
      .BANK_IDX (b)
    ) i_arbiter (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .init_req (init_req),
      .init_gnt (arb_gnt[b]),
      .bank_req (arb_req[b]),
      .bank_gnt (flt_gnt[b])
    );

    tcdm_r_id_filter i_id_filter (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .clear_i    (clear_i),
      .enable_i   (enable_i),
      .target_req (arb_req[b]),
      .target_gnt (flt_gnt[b]),
      .target_rsp (flt_rsp[b]),
      .init_req   (mem_req[b]),
      .init_gnt   (mem_gnt[b]),
      .init_rsp   (mem_rsp[b])
    );

    tcdm_bank_mem i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .mem_req (mem_req[b]),
      .mem_gnt (mem_gnt[b]),
      .mem_rsp (mem_rsp[b])
    );
  end

  // An initiator targets one bank per cycle so the grant vectors never overlap
  always_comb begin
    init_gnt = '0;
    for (int unsigned b = 0; b < tcdm_pkg::NB_BANK; b++) begin
      init_gnt = init_gnt | arb_gnt[b];
    end
  end

  // ########################################
  // Response return
  // ########################################

  tcdm_resp_router i_router (
    .bank_rsp (flt_rsp),
    .init_rsp (init_rsp)
  );

endmodule

// ==== verification/tb_tcdm_model.svh ====
`ifndef TB_TCDM_MODEL_SVH
`define TB_TCDM_MODEL_SVH

// ########################################
// Reference state
// ########################################

// Shadow copy of the whole word address space, indexed like the initiators see it
logic [tcdm_pkg::DW-1:0] shadow_mem [2**tcdm_pkg::AW];
int err_cnt = 0;  // Failed checks so far
int chk_cnt = 0;  // Checks performed so far

// Linear congruential step with the usual 32-bit constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Applies one granted operation to the shadow memory
// Returns the word a read must deliver one cycle after its grant
function automatic logic [tcdm_pkg::DW-1:0] ref_mem_apply(input logic [tcdm_pkg::AW-1:0] add,
                                                        input tcdm_pkg::tcdm_op_e op,
                                                        input logic [tcdm_pkg::BW-1:0] be,
                                                        input logic [tcdm_pkg::DW-1:0] data);
  if (op == tcdm_pkg::OP_WRITE) begin
    for (int b = 0; b < int'(tcdm_pkg::BW); b++) begin
      if (be[b]) shadow_mem[add][b*8 +: 8] = data[b*8 +: 8];  // Only enabled bytes change
    end
  end
  return shadow_mem[add];
endfunction

// Round-robin pick among the requesters in mask, starting at ptr
// Returns -1 when nobody asks
function automatic int rr_pick(input logic [tcdm_pkg::NB_INIT-1:0] mask, input int ptr);
  int cand;
  for (int off = 0; off < int'(tcdm_pkg::NB_INIT); off++) begin
    cand = (ptr + off) % int'(tcdm_pkg::NB_INIT);
    if (mask[cand]) return cand;
  end
  return -1;
endfunction

// ########################################
// Typed compare tasks
// ########################################

// Data and id only matter when a response is expected
task automatic compare_rsp(input string name, input tcdm_pkg::tcdm_rsp_t got,
                           input tcdm_pkg::tcdm_rsp_t exp);
  chk_cnt++;
  if (got.r_valid !== exp.r_valid) begin
    err_cnt++;
    $display("Error: %s.r_valid is 0x%h, expected 0x%h", name, got.r_valid, exp.r_valid);
  end else if (exp.r_valid) begin
    if (got.r_data !== exp.r_data) begin
      err_cnt++;
      $display("Error: %s.r_data is 0x%h, expected 0x%h", name, got.r_data, exp.r_data);
    end
    if (got.r_id !== exp.r_id) begin
      err_cnt++;
      $display("Error: %s.r_id is 0x%h, expected 0x%h", name, got.r_id, exp.r_id);
    end
  end
endtask

// One bit of the grant vector against the reference arbiter
task automatic compare_gnt(input string name, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
  end
endtask

`endif

// ==== verification/tb_tcdm_cluster.sv ====
`timescale 1ns/1ns

module tb_tcdm_cluster;

  localparam int FILL_WORDS = 16;  // Addresses 0 to 15 cover both banks
  localparam int CONT_READS = 3;   // Reads per initiator in the contention test
  localparam int RAND_OPS   = 24;  // Random operations per initiator
  localparam int MAX_OPS    = 32;  // Room in each per-initiator op list
  localparam int TOTAL_OPS  = 4 * FILL_WORDS + 4 * CONT_READS + 4 * RAND_OPS + 3;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_OPS + 200;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         clear_i;
  logic                         enable_i;
  tcdm_pkg::tcdm_req_t          init_req [tcdm_pkg::NB_INIT];
  logic [tcdm_pkg::NB_INIT-1:0] init_gnt;
  tcdm_pkg::tcdm_rsp_t          init_rsp [tcdm_pkg::NB_INIT];

  `include "tb_tcdm_model.svh"

  tcdm_pkg::tcdm_req_t op_list [tcdm_pkg::NB_INIT][MAX_OPS];  // Requests queued per initiator
  int                  op_dst  [tcdm_pkg::NB_INIT][MAX_OPS];  // Initiator that gets the answer
  int                  op_cnt  [tcdm_pkg::NB_INIT];
  tcdm_pkg::tcdm_rsp_t exp_rsp [tcdm_pkg::NB_INIT];  // Response due at the next check
  int                  rr_ref  [tcdm_pkg::NB_BANK];  // Reference round-robin pointers
  logic [31:0]         lcg_state = 32'd57496;
  int                  ops_done = 0;
  int                  err_mark;
  int                  ops_mark;

  tcdm_cluster_top i_dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .enable_i (enable_i),
    .init_req (init_req),
    .init_gnt (init_gnt),
    .init_rsp (init_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns period
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
  endfunction

  // Fill value built from every address bit
  function automatic logic [31:0] fill_word(input logic [tcdm_pkg::AW-1:0] add);
    return {6'h2d, add, 6'h12, add};
  endfunction

  task automatic add_op(input int k, input logic [tcdm_pkg::AW-1:0] add,
                        input tcdm_pkg::tcdm_op_e op, input logic [tcdm_pkg::BW-1:0] be,
                        input logic [tcdm_pkg::DW-1:0] data, input int dst);
    tcdm_pkg::tcdm_req_t r;
    r      = '0;  // Id stays zero because the arbiter fills it in
    r.req  = 1'b1;
    r.add  = add;
    r.op   = op;
    r.be   = be;
    r.data = data;
    op_list[k][op_cnt[k]] = r;
    op_dst[k][op_cnt[k]]  = dst;
    op_cnt[k]++;
  endtask

  // ########################################
  // Initiator drivers
  // ########################################

  // Called at a rising edge and returns at the grant edge
  task automatic issue_op(input int k, input tcdm_pkg::tcdm_req_t r, input int dst);
    int                      waited;
    logic [tcdm_pkg::DW-1:0] word;
    tcdm_pkg::tcdm_rsp_t     e;
    init_req[k] <= r;
    waited = 0;
    do begin
      @(negedge clk_i);  // Grant is stable between edges
      waited++;
    end while (!init_gnt[k]);
    if (waited > int'(tcdm_pkg::NB_INIT)) begin
      err_cnt++;
      $display("Initiator %0d waited %0d cycles for a grant, more than allowed", k, waited);
    end
    word = ref_mem_apply(r.add, r.op, r.be, r.data);
    @(posedge clk_i);  // The transfer happens here
    if (r.op == tcdm_pkg::OP_READ) begin
      e.r_valid    = 1'b1;
      e.r_data     = word;
      e.r_id       = dst[tcdm_pkg::IW-1:0];
      exp_rsp[dst] = e;  // Due in the cycle after this edge
    end
    ops_done++;
  endtask

  task automatic drive_ops(input int k);
    for (int n = 0; n < op_cnt[k]; n++) begin
      issue_op(k, op_list[k][n], op_dst[k][n]);
    end
    init_req[k] <= '0;  // Idle once the list is empty
  endtask

  // Waits until every expected response has been checked
  task automatic wait_drain();
    logic pending;
    pending = 1'b1;
    while (pending) begin
      @(posedge clk_i);
      pending = 1'b0;
      for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) pending |= exp_rsp[k].r_valid;
    end
  endtask

  task automatic run_ops();
    @(posedge clk_i);
    fork
      drive_ops(0);
      drive_ops(1);
      drive_ops(2);
      drive_ops(3);
    join
    wait_drain();
    for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) op_cnt[k] = 0;
  endtask

  task automatic start_test();
    err_mark = err_cnt;
    ops_mark = ops_done;
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d operations, %0d errors", num, name, ops_done - ops_mark,
             err_cnt - err_mark);
  endtask

  // ########################################
  // Checker
  // ########################################

  // Grants are compared with a reference round-robin and responses with their slots
  always @(negedge clk_i) begin : check_outputs
    logic [tcdm_pkg::NB_INIT-1:0] mask;
    logic [tcdm_pkg::NB_INIT-1:0] exp_gnt;
    int                           win;
    if (!rst_ni) begin
      for (int b = 0; b < int'(tcdm_pkg::NB_BANK); b++) rr_ref[b] = 0;
    end else begin
      exp_gnt = '0;
      for (int b = 0; b < int'(tcdm_pkg::NB_BANK); b++) begin
        for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) begin
          mask[k] = init_req[k].req && (init_req[k].add[0] == b[0]);
        end
        win = rr_pick(mask, rr_ref[b]);
        if (win >= 0) begin
          exp_gnt[win] = 1'b1;
          rr_ref[b]    = (win + 1) % int'(tcdm_pkg::NB_INIT);  // Winner goes last
        end
      end
      for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) begin
        compare_gnt($sformatf("init_gnt[%0d]", k), init_gnt[k], exp_gnt[k]);
        compare_rsp($sformatf("init_rsp[%0d]", k), init_rsp[k], exp_rsp[k]);
        exp_rsp[k] = '0;  // An empty slot means no response is allowed
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ########################################
  // Test sequence
  // ########################################

  initial begin : test_sequence
    logic [31:0] rnd;
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    enable_i = 1'b1;
    for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) begin
      init_req[k] = '0;
      exp_rsp[k]  = '0;
      op_cnt[k]   = 0;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test();
    for (int a = 0; a < FILL_WORDS; a++) begin
      add_op(0, a[tcdm_pkg::AW-1:0], tcdm_pkg::OP_WRITE, '1, fill_word(a[tcdm_pkg::AW-1:0]), 0);
    end
    for (int a = 0; a < FILL_WORDS; a++) begin
      add_op(0, a[tcdm_pkg::AW-1:0], tcdm_pkg::OP_READ, '0, '0, 0);
    end
    run_ops();
    end_test(1, "single initiator write and readback");

    start_test();
    for (int a = 0; a < FILL_WORDS; a++) begin
      rnd = next_rand();
      add_op(0, a[tcdm_pkg::AW-1:0], tcdm_pkg::OP_WRITE, rnd[27:24], next_rand(), 0);
    end
    for (int a = 0; a < FILL_WORDS; a++) begin
      add_op(0, a[tcdm_pkg::AW-1:0], tcdm_pkg::OP_READ, '0, '0, 0);
    end
    run_ops();
    end_test(2, "byte enables");

    start_test();
    for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) begin
      for (int n = 0; n < CONT_READS; n++) begin
        rnd = next_rand();
        add_op(k, {6'd0, rnd[22:20], 1'b1}, tcdm_pkg::OP_READ, '0, '0, k);  // Odd bank only
      end
    end
    run_ops();
    end_test(3, "contention");

    start_test();
    for (int k = 0; k < int'(tcdm_pkg::NB_INIT); k++) begin
      for (int n = 0; n < RAND_OPS; n++) begin
        rnd = next_rand();
        add_op(k, {6'd0, rnd[19:16]}, rnd[31] ? tcdm_pkg::OP_READ : tcdm_pkg::OP_WRITE,
               rnd[27:24], next_rand(), k);
      end
    end
    run_ops();
    end_test(4, "random traffic");

    start_test();
    add_op(3, 10'd5, tcdm_pkg::OP_READ, '0, '0, 3);  // Leaves tag 3 stored in bank 1
    run_ops();
    @(posedge clk_i);
    clear_i  <= 1'b1;
    enable_i <= 1'b0;  // Stored ids freeze at zero
    @(posedge clk_i);
    clear_i <= 1'b0;
    add_op(2, 10'd5, tcdm_pkg::OP_READ, '0, '0, 0);  // Answer lands at initiator 0
    run_ops();
    @(posedge clk_i);
    enable_i <= 1'b1;
    add_op(2, 10'd5, tcdm_pkg::OP_READ, '0, '0, 2);
    run_ops();
    end_test(5, "clear and enable");

    $display("Summary: 5 tests, %0d operations, %0d checks, %0d errors", ops_done, chk_cnt,
             err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verification
verilog/tcdm_pkg.sv
verilog/tcdm_r_id_filter.sv
verilog/tcdm_bank_arbiter.sv
verilog/tcdm_bank_mem.sv
verilog/tcdm_resp_router.sv
verilog/tcdm_cluster_top.sv
verification/tb_tcdm_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cluster testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f files.f \
  --top-module tb_tcdm_cluster \
  -o sim_tcdm

./obj_dir/sim_tcdm > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
